// File: rtl/gnn_debug_pkg.sv
package gnn_debug_pkg;

  localparam int NUM_SPARSE_DATA = 12;
  localparam int NUM_LANES       = 16;
  localparam int LANE_W          = 12;
  localparam int LANE_SEL_W      = $clog2(NUM_LANES);
  localparam int WH_ADDR_W       = 14;
  localparam int FEAT_ADDR_W     = 16;
  localparam int REG_ADDR_W      = 8;
  localparam int NUM_REGS        = 10;
  localparam int SEL_W           = $clog2(NUM_REGS + 1); // room for SEL_NONE.

  localparam logic [REG_ADDR_W-1:0] REG_ID          = 8'h00;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS      = 8'h04;
  localparam logic [REG_ADDR_W-1:0] REG_CTRL        = 8'h08;
  localparam logic [REG_ADDR_W-1:0] REG_CAP_ADDR0   = 8'h0C;
  localparam logic [REG_ADDR_W-1:0] REG_CAP_ADDR1   = 8'h10;
  localparam logic [REG_ADDR_W-1:0] REG_CAP_DATA0   = 8'h14;
  localparam logic [REG_ADDR_W-1:0] REG_CAP_DATA1   = 8'h18;
  localparam logic [REG_ADDR_W-1:0] REG_CNT_LO      = 8'h1C;
  localparam logic [REG_ADDR_W-1:0] REG_CNT_HI      = 8'h20;
  localparam logic [REG_ADDR_W-1:0] REG_FEAT_THRESH = 8'h24;

  localparam logic [WH_ADDR_W-1:0]   CAP_ADDR0_RST   = 14'd10;
  localparam logic [WH_ADDR_W-1:0]   CAP_ADDR1_RST   = 14'd20;
  localparam logic [FEAT_ADDR_W-1:0] FEAT_THRESH_RST = 16'd43328;
  localparam logic [LANE_SEL_W-1:0]  CAP_LANE_RST    = 4'd2;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  typedef enum logic [SEL_W-1:0] {
    SEL_ID, SEL_STATUS, SEL_CTRL, SEL_CAP_ADDR0, SEL_CAP_ADDR1,
    SEL_CAP_DATA0, SEL_CAP_DATA1, SEL_CNT_LO, SEL_CNT_HI, SEL_FEAT_THRESH,
    SEL_NONE
  } reg_sel_e;

endpackage

// File: rtl/dbg_axil_decode.sv
module dbg_axil_decode (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 s_awvalid_i,
  output logic                                 s_awready_o,
  input  logic [gnn_debug_pkg::REG_ADDR_W-1:0] s_awaddr_i,
  input  logic                                 s_wvalid_i,
  output logic                                 s_wready_o,
  input  logic [31:0]                          s_wdata_i,
  output logic                                 s_bvalid_o,
  input  logic                                 s_bready_i,
  output gnn_debug_pkg::axil_resp_e            s_bresp_o,
  input  logic                                 s_arvalid_i,
  output logic                                 s_arready_o,
  input  logic [gnn_debug_pkg::REG_ADDR_W-1:0] s_araddr_i,
  input  logic                                 rvalid_i,
  output logic                                 wr_pulse_o,
  output gnn_debug_pkg::reg_sel_e              wr_sel_o,
  output logic [31:0]                          wr_data_o,
  output logic                                 rd_pulse_o,
  output gnn_debug_pkg::reg_sel_e              rd_sel_o
);
  import gnn_debug_pkg::*;

  logic     wr_accept;
  logic     wr_legal;
  reg_sel_e aw_sel;

  function automatic reg_sel_e decode_sel(input logic [REG_ADDR_W-1:0] addr);
    reg_sel_e sel;
    case (addr)
      REG_ID:          sel = SEL_ID;
      REG_STATUS:      sel = SEL_STATUS;
      REG_CTRL:        sel = SEL_CTRL;
      REG_CAP_ADDR0:   sel = SEL_CAP_ADDR0;
      REG_CAP_ADDR1:   sel = SEL_CAP_ADDR1;
      REG_CAP_DATA0:   sel = SEL_CAP_DATA0;
      REG_CAP_DATA1:   sel = SEL_CAP_DATA1;
      REG_CNT_LO:      sel = SEL_CNT_LO;
      REG_CNT_HI:      sel = SEL_CNT_HI;
      REG_FEAT_THRESH: sel = SEL_FEAT_THRESH;
      default:         sel = SEL_NONE;
    endcase
    return sel;
  endfunction

  // write channel: AW and W are taken together.
  assign aw_sel    = decode_sel(s_awaddr_i);
  assign wr_legal  = aw_sel inside {SEL_CTRL, SEL_CAP_ADDR0, SEL_CAP_ADDR1, SEL_FEAT_THRESH};
  assign wr_accept = s_awvalid_i && s_wvalid_i && !s_bvalid_o; // stall while B pending.

  assign s_awready_o = wr_accept;
  assign s_wready_o  = wr_accept;

  assign wr_pulse_o = wr_accept && wr_legal; // illegal writes are dropped.
  assign wr_sel_o   = aw_sel;
  assign wr_data_o  = s_wdata_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s_bvalid_o <= 1'b0;
    end else if (wr_accept) begin
      s_bvalid_o <= 1'b1;
    end else if (s_bready_i) begin
      s_bvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      s_bresp_o <= wr_legal ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // read channel: one beat in flight at most.
  assign s_arready_o = !rvalid_i;
  assign rd_pulse_o  = s_arvalid_i && s_arready_o;
  assign rd_sel_o    = decode_sel(s_araddr_i);

endmodule

// File: rtl/dbg_event_monitor.sv
module dbg_event_monitor (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic                                              wr_pulse_i,
  input  gnn_debug_pkg::reg_sel_e                           wr_sel_i,
  input  logic [31:0]                                       wr_data_i,
  input  logic                                              spmm_vld_i,
  input  logic                                              spmm_rdy_i,
  input  logic                                              dmvm_vld_i,
  input  logic                                              dmvm_rdy_i,
  input  logic                                              sm_vld_i,
  input  logic                                              sm_rdy_i,
  input  logic                                              aggr_vld_i,
  input  logic                                              aggr_rdy_i,
  input  logic                                              feat_wr_en_i,
  input  logic [gnn_debug_pkg::FEAT_ADDR_W-1:0]             feat_wr_addr_i,
  input  logic [gnn_debug_pkg::WH_ADDR_W-1:0]               wh_addr_i,
  input  logic [gnn_debug_pkg::NUM_LANES*gnn_debug_pkg::LANE_W-1:0] sppe_lanes_i,
  output logic [31:0]                                       status_o,
  output logic [31:0]                                       ctrl_o,
  output logic [31:0]                                       cap_addr0_o,
  output logic [31:0]                                       cap_addr1_o,
  output logic [31:0]                                       cap_data0_o,
  output logic [31:0]                                       cap_data1_o,
  output logic [31:0]                                       feat_thresh_o,
  output logic [63:0]                                       count_o
);
  import gnn_debug_pkg::*;

  logic [7:0]             hs_flags;
  logic [7:0]             hs_now;
  logic                   feat_flag;
  logic                   feat_hit;
  logic [63:0]            count;
  logic [LANE_W-1:0]      cap_data0;
  logic [LANE_W-1:0]      cap_data1;
  logic [LANE_W-1:0]      lane_val;
  logic [WH_ADDR_W-1:0]   cap_addr0;
  logic [WH_ADDR_W-1:0]   cap_addr1;
  logic [FEAT_ADDR_W-1:0] feat_thresh;
  logic [LANE_SEL_W-1:0]  cap_lane;
  logic                   clr;

  assign clr      = wr_pulse_i && (wr_sel_i == SEL_CTRL) && wr_data_i[0];
  assign hs_now   = {spmm_vld_i, spmm_rdy_i, dmvm_vld_i, dmvm_rdy_i,
                     sm_vld_i, sm_rdy_i, aggr_vld_i, aggr_rdy_i};
  assign feat_hit = feat_wr_en_i && (feat_wr_addr_i >= feat_thresh);
  assign lane_val = sppe_lanes_i[cap_lane*LANE_W +: LANE_W];

  // host configuration.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_lane    <= CAP_LANE_RST;
      cap_addr0   <= CAP_ADDR0_RST;
      cap_addr1   <= CAP_ADDR1_RST;
      feat_thresh <= FEAT_THRESH_RST;
    end else if (wr_pulse_i) begin
      case (wr_sel_i)
        SEL_CTRL:        cap_lane    <= wr_data_i[4 +: LANE_SEL_W];
        SEL_CAP_ADDR0:   cap_addr0   <= wr_data_i[WH_ADDR_W-1:0];
        SEL_CAP_ADDR1:   cap_addr1   <= wr_data_i[WH_ADDR_W-1:0];
        SEL_FEAT_THRESH: feat_thresh <= wr_data_i[FEAT_ADDR_W-1:0];
        default: ;
      endcase
    end
  end

  // event state, clear wins over same-cycle events.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hs_flags  <= '0;
      feat_flag <= 1'b0;
      count     <= '0;
      cap_data0 <= '0;
      cap_data1 <= '0;
    end else if (clr) begin
      hs_flags  <= '0;
      feat_flag <= 1'b0;
      count     <= '0;
      cap_data0 <= '0;
      cap_data1 <= '0;
    end else begin
      hs_flags  <= hs_flags | hs_now; // sticky.
      feat_flag <= feat_flag | feat_hit;
      count     <= count + 64'(sm_vld_i);
      if (spmm_rdy_i && (wh_addr_i == cap_addr0)) begin
        cap_data0 <= lane_val;
      end
      if (spmm_rdy_i && (wh_addr_i == cap_addr1)) begin
        cap_data1 <= lane_val;
      end
    end
  end

  assign status_o      = {23'b0, feat_flag, hs_flags};
  assign ctrl_o        = {{(28 - LANE_SEL_W){1'b0}}, cap_lane, 4'b0}; // bit 0 self clears.
  assign cap_addr0_o   = 32'(cap_addr0);
  assign cap_addr1_o   = 32'(cap_addr1);
  assign cap_data0_o   = 32'(cap_data0);
  assign cap_data1_o   = 32'(cap_data1);
  assign feat_thresh_o = 32'(feat_thresh);
  assign count_o       = count;

endmodule

// File: rtl/dbg_read_result.sv
module dbg_read_result (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      rd_pulse_i,
  input  gnn_debug_pkg::reg_sel_e   rd_sel_i,
  input  logic [31:0]               status_i,
  input  logic [31:0]               ctrl_i,
  input  logic [31:0]               cap_addr0_i,
  input  logic [31:0]               cap_addr1_i,
  input  logic [31:0]               cap_data0_i,
  input  logic [31:0]               cap_data1_i,
  input  logic [31:0]               feat_thresh_i,
  input  logic [63:0]               count_i,
  output logic                      s_rvalid_o,
  output logic [31:0]               s_rdata_o,
  output gnn_debug_pkg::axil_resp_e s_rresp_o,
  input  logic                      s_rready_i
);
  import gnn_debug_pkg::*;

  logic [31:0] rd_word;
  logic [31:0] cnt_hi_shadow;

  always_comb begin
    case (rd_sel_i)
      SEL_ID:          rd_word = 32'(NUM_SPARSE_DATA);
      SEL_STATUS:      rd_word = status_i;
      SEL_CTRL:        rd_word = ctrl_i;
      SEL_CAP_ADDR0:   rd_word = cap_addr0_i;
      SEL_CAP_ADDR1:   rd_word = cap_addr1_i;
      SEL_CAP_DATA0:   rd_word = cap_data0_i;
      SEL_CAP_DATA1:   rd_word = cap_data1_i;
      SEL_CNT_LO:      rd_word = count_i[31:0];
      SEL_CNT_HI:      rd_word = cnt_hi_shadow; // latched by the CNT_LO read.
      SEL_FEAT_THRESH: rd_word = feat_thresh_i;
      default:         rd_word = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s_rvalid_o    <= 1'b0;
      cnt_hi_shadow <= '0;
    end else if (rd_pulse_i) begin
      s_rvalid_o <= 1'b1;
      if (rd_sel_i == SEL_CNT_LO) begin
        cnt_hi_shadow <= count_i[63:32];
      end
    end else if (s_rready_i) begin
      s_rvalid_o <= 1'b0;
    end
  end

  // beat payload, held until the next accept.
  always_ff @(posedge clk) begin
    if (rd_pulse_i) begin
      s_rdata_o <= rd_word;
      s_rresp_o <= (rd_sel_i == SEL_NONE) ? RESP_SLVERR : RESP_OKAY;
    end
  end

endmodule

// File: rtl/gnn_debug_top.sv
module gnn_debug_top (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic                                              s_awvalid_i,
  output logic                                              s_awready_o,
  input  logic [gnn_debug_pkg::REG_ADDR_W-1:0]              s_awaddr_i,
  input  logic                                              s_wvalid_i,
  output logic                                              s_wready_o,
  input  logic [31:0]                                       s_wdata_i,
  output logic                                              s_bvalid_o,
  input  logic                                              s_bready_i,
  output gnn_debug_pkg::axil_resp_e                         s_bresp_o,
  input  logic                                              s_arvalid_i,
  output logic                                              s_arready_o,
  input  logic [gnn_debug_pkg::REG_ADDR_W-1:0]              s_araddr_i,
  output logic                                              s_rvalid_o,
  input  logic                                              s_rready_i,
  output logic [31:0]                                       s_rdata_o,
  output gnn_debug_pkg::axil_resp_e                         s_rresp_o,
  input  logic                                              spmm_vld_i,
  input  logic                                              spmm_rdy_i,
  input  logic                                              dmvm_vld_i,
  input  logic                                              dmvm_rdy_i,
  input  logic                                              sm_vld_i,
  input  logic                                              sm_rdy_i,
  input  logic                                              aggr_vld_i,
  input  logic                                              aggr_rdy_i,
  input  logic                                              feat_wr_en_i,
  input  logic [gnn_debug_pkg::FEAT_ADDR_W-1:0]             feat_wr_addr_i,
  input  logic [gnn_debug_pkg::WH_ADDR_W-1:0]               wh_addr_i,
  input  logic [gnn_debug_pkg::NUM_LANES*gnn_debug_pkg::LANE_W-1:0] sppe_lanes_i
);
  import gnn_debug_pkg::*;

  logic        wr_pulse;
  reg_sel_e    wr_sel;
  logic [31:0] wr_data;
  logic        rd_pulse;
  reg_sel_e    rd_sel;
  logic [31:0] status;
  logic [31:0] ctrl;
  logic [31:0] cap_addr0;
  logic [31:0] cap_addr1;
  logic [31:0] cap_data0;
  logic [31:0] cap_data1;
  logic [31:0] feat_thresh;
  logic [63:0] count;

  dbg_axil_decode u_decode (
    .clk, .rst_n,
    .s_awvalid_i, .s_awready_o, .s_awaddr_i,
    .s_wvalid_i, .s_wready_o, .s_wdata_i,
    .s_bvalid_o, .s_bready_i, .s_bresp_o,
    .s_arvalid_i, .s_arready_o, .s_araddr_i,
    .rvalid_i   (s_rvalid_o), // R channel busy.
    .wr_pulse_o (wr_pulse), .wr_sel_o (wr_sel), .wr_data_o (wr_data),
    .rd_pulse_o (rd_pulse), .rd_sel_o (rd_sel)
  );

  dbg_event_monitor u_monitor (
    .clk, .rst_n,
    .wr_pulse_i (wr_pulse), .wr_sel_i (wr_sel), .wr_data_i (wr_data),
    .spmm_vld_i, .spmm_rdy_i, .dmvm_vld_i, .dmvm_rdy_i,
    .sm_vld_i, .sm_rdy_i, .aggr_vld_i, .aggr_rdy_i,
    .feat_wr_en_i, .feat_wr_addr_i, .wh_addr_i, .sppe_lanes_i,
    .status_o (status), .ctrl_o (ctrl),
    .cap_addr0_o (cap_addr0), .cap_addr1_o (cap_addr1),
    .cap_data0_o (cap_data0), .cap_data1_o (cap_data1),
    .feat_thresh_o (feat_thresh), .count_o (count)
  );

  dbg_read_result u_result (
    .clk, .rst_n,
    .rd_pulse_i (rd_pulse), .rd_sel_i (rd_sel),
    .status_i (status), .ctrl_i (ctrl),
    .cap_addr0_i (cap_addr0), .cap_addr1_i (cap_addr1),
    .cap_data0_i (cap_data0), .cap_data1_i (cap_data1),
    .feat_thresh_i (feat_thresh), .count_i (count),
    .s_rvalid_o, .s_rdata_o, .s_rresp_o, .s_rready_i
  );

endmodule

// File: sim/gnn_debug_checker.sv
module gnn_debug_checker (
  input logic        clk,
  input logic        rst_n,
  input logic        bvalid_i,
  input logic        bready_i,
  input logic        arvalid_i,
  input logic        arready_i,
  input logic        rvalid_i,
  input logic        rready_i,
  input logic [31:0] rdata_i
);
  int fail_cnt = 0;

  bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid_i && !bready_i |=> bvalid_i)
    else begin
      $error("B response dropped before its ready.");
      fail_cnt++;
    end

  rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i && !rready_i |=> rvalid_i)
    else begin
      $error("R beat dropped before its ready.");
      fail_cnt++;
    end

  rdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i && !rready_i |=> $stable(rdata_i))
    else begin
      $error("R data changed while the beat was stalled.");
      fail_cnt++;
    end

  // accepted read gives a beat next cycle.
  ar_to_r: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid_i && arready_i |=> rvalid_i)
    else begin
      $error("No R beat followed an accepted read.");
      fail_cnt++;
    end

endmodule

bind gnn_debug_top gnn_debug_checker u_checker (
  .clk,
  .rst_n,
  .bvalid_i  (s_bvalid_o),
  .bready_i  (s_bready_i),
  .arvalid_i (s_arvalid_i),
  .arready_i (s_arready_o),
  .rvalid_i  (s_rvalid_o),
  .rready_i  (s_rready_i),
  .rdata_i   (s_rdata_o)
);

// File: sim/tb_gnn_debug.sv
module tb_gnn_debug;
  import gnn_debug_pkg::*;

  logic clk = 1'b0;
  logic rst_n;
  logic s_awvalid_i, s_wvalid_i, s_bready_i, s_arvalid_i, s_rready_i;
  logic s_awready_o, s_wready_o, s_bvalid_o, s_arready_o, s_rvalid_o;
  logic [REG_ADDR_W-1:0] s_awaddr_i, s_araddr_i;
  logic [31:0] s_wdata_i, s_rdata_o;
  axil_resp_e s_bresp_o, s_rresp_o;
  logic spmm_vld_i, spmm_rdy_i, dmvm_vld_i, dmvm_rdy_i;
  logic sm_vld_i, sm_rdy_i, aggr_vld_i, aggr_rdy_i;
  logic feat_wr_en_i;
  logic [FEAT_ADDR_W-1:0] feat_wr_addr_i;
  logic [WH_ADDR_W-1:0] wh_addr_i;
  logic [NUM_LANES*LANE_W-1:0] sppe_lanes_i;

  logic [7:0] hs; // spmm vld in bit 7.
  logic probe_en;
  logic [WH_ADDR_W-1:0] tgt0, tgt1;
  logic [7:0] m_flags;
  logic m_feat;
  logic [63:0] m_count;
  logic [31:0] m_cap0, m_cap1, m_shadow, m_rd_data;
  logic [WH_ADDR_W-1:0] m_addr0, m_addr1;
  logic [FEAT_ADDR_W-1:0] m_thresh;
  logic [3:0] m_lane;
  axil_resp_e m_rd_resp;
  logic wr_hit, clr;

  gnn_debug_top UUT (.*);

  always #2 clk = ~clk;

  assign {spmm_vld_i, spmm_rdy_i, dmvm_vld_i, dmvm_rdy_i,
          sm_vld_i, sm_rdy_i, aggr_vld_i, aggr_rdy_i} = hs;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("ERROR at time %0t: %s gave 0x%08h, expected 0x%08h",
                          $time, what, got, exp));
  endtask

  task automatic check_resp(input string what, input axil_resp_e got, input axil_resp_e exp);
    if (got !== exp)
      abort_run($sformatf("ERROR at time %0t: %s response %b, expected %b",
                          $time, what, got, exp));
  endtask

  task automatic tick(ref int n, input string what);
    @(posedge clk);
    n++;
    if (n > 200) abort_run($sformatf("timed out waiting for %s", what));
  endtask

  function automatic logic writable(input logic [REG_ADDR_W-1:0] a);
    return a inside {REG_CTRL, REG_CAP_ADDR0, REG_CAP_ADDR1, REG_FEAT_THRESH};
  endfunction

  function automatic logic mapped(input logic [REG_ADDR_W-1:0] a);
    return (a[1:0] == 2'b00) && (a <= REG_FEAT_THRESH); // offsets are contiguous.
  endfunction

  function automatic logic [31:0] model_word(input logic [REG_ADDR_W-1:0] a);
    case (a)
      REG_ID:          return 32'(NUM_SPARSE_DATA);
      REG_STATUS:      return {23'b0, m_feat, m_flags};
      REG_CTRL:        return {24'b0, m_lane, 4'b0};
      REG_CAP_ADDR0:   return 32'(m_addr0);
      REG_CAP_ADDR1:   return 32'(m_addr1);
      REG_CAP_DATA0:   return m_cap0;
      REG_CAP_DATA1:   return m_cap1;
      REG_CNT_LO:      return m_count[31:0];
      REG_CNT_HI:      return m_shadow;
      REG_FEAT_THRESH: return 32'(m_thresh);
      default:         return '0;
    endcase
  endfunction

  function automatic logic [7:0] rare_bits();
    logic [7:0] b;
    for (int i = 0; i < 8; i++)
      b[i] = ($urandom % 16) == 0;
    return b;
  endfunction

  task automatic axi_write(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
    int n;
    s_awvalid_i <= 1'b1;
    s_awaddr_i  <= addr;
    s_wvalid_i  <= 1'b1;
    s_wdata_i   <= data;
    n = 0;
    do tick(n, "write accept"); while (!(s_awready_o && s_wready_o));
    s_awvalid_i <= 1'b0;
    s_wvalid_i  <= 1'b0;
    repeat ($urandom % 4) @(posedge clk);
    s_bready_i <= 1'b1;
    n = 0;
    do tick(n, "write response"); while (!(s_bvalid_o && s_bready_i));
    check_resp($sformatf("write 0x%02h", addr), s_bresp_o,
               writable(addr) ? RESP_OKAY : RESP_SLVERR);
    s_bready_i <= 1'b0;
  endtask

  task automatic axi_read(input logic [REG_ADDR_W-1:0] addr, input int delay);
    int n;
    s_arvalid_i <= 1'b1;
    s_araddr_i  <= addr;
    n = 0;
    do tick(n, "read accept"); while (!s_arready_o);
    s_arvalid_i <= 1'b0;
    repeat (delay + $urandom % 4) @(posedge clk);
    s_rready_i <= 1'b1;
    n = 0;
    do tick(n, "read data"); while (!(s_rvalid_o && s_rready_i));
    check_word($sformatf("read 0x%02h", addr), s_rdata_o, m_rd_data);
    check_resp($sformatf("read 0x%02h", addr), s_rresp_o, m_rd_resp);
    s_rready_i <= 1'b0;
  endtask

  task automatic read_all(input int delay);
    for (int a = 0; a <= REG_FEAT_THRESH; a += 4)
      axi_read(REG_ADDR_W'(a), delay);
  endtask

  always @(posedge clk) begin
    hs             <= probe_en ? rare_bits() : 8'h00;
    feat_wr_en_i   <= probe_en && (($urandom % 8) == 0);
    feat_wr_addr_i <= FEAT_ADDR_W'($urandom);
    wh_addr_i      <= ((($urandom % 2) == 0) ? tgt0 : tgt1) + WH_ADDR_W'($urandom % 4);
    sppe_lanes_i   <= {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom};
  end

  assign wr_hit = s_awvalid_i && s_wvalid_i && s_awready_o && s_wready_o &&
                  writable(s_awaddr_i);
  assign clr    = wr_hit && (s_awaddr_i == REG_CTRL) && s_wdata_i[0];

  always @(posedge clk) begin
    if (!rst_n) begin
      m_flags  <= '0;
      m_feat   <= 1'b0;
      m_count  <= '0;
      m_cap0   <= '0;
      m_cap1   <= '0;
      m_shadow <= '0;
      m_addr0  <= CAP_ADDR0_RST;
      m_addr1  <= CAP_ADDR1_RST;
      m_thresh <= FEAT_THRESH_RST;
      m_lane   <= CAP_LANE_RST;
    end else begin
      if (s_arvalid_i && s_arready_o) begin
        m_rd_data <= model_word(s_araddr_i); // state before this edge.
        m_rd_resp <= mapped(s_araddr_i) ? RESP_OKAY : RESP_SLVERR;
        if (s_araddr_i == REG_CNT_LO) begin
          m_shadow <= m_count[63:32];
        end
      end
      if (wr_hit) begin
        case (s_awaddr_i)
          REG_CTRL:        m_lane   <= s_wdata_i[7:4];
          REG_CAP_ADDR0:   m_addr0  <= s_wdata_i[WH_ADDR_W-1:0];
          REG_CAP_ADDR1:   m_addr1  <= s_wdata_i[WH_ADDR_W-1:0];
          REG_FEAT_THRESH: m_thresh <= s_wdata_i[FEAT_ADDR_W-1:0];
          default: ;
        endcase
      end
      if (clr) begin
        m_flags <= '0;
        m_feat  <= 1'b0;
        m_count <= '0;
        m_cap0  <= '0;
        m_cap1  <= '0;
      end else begin
        m_flags <= m_flags | hs;
        m_feat  <= m_feat | (feat_wr_en_i && (feat_wr_addr_i >= m_thresh));
        m_count <= m_count + 64'(sm_vld_i);
        if (spmm_rdy_i && (wh_addr_i == m_addr0))
          m_cap0 <= 32'(sppe_lanes_i[m_lane*LANE_W +: LANE_W]);
        if (spmm_rdy_i && (wh_addr_i == m_addr1))
          m_cap1 <= 32'(sppe_lanes_i[m_lane*LANE_W +: LANE_W]);
      end
    end
  end

  initial begin
    void'($urandom(44004));
    rst_n          <= 1'b0;
    s_awvalid_i    <= 1'b0;
    s_wvalid_i     <= 1'b0;
    s_bready_i     <= 1'b0;
    s_arvalid_i    <= 1'b0;
    s_rready_i     <= 1'b0;
    s_awaddr_i     <= '0;
    s_araddr_i     <= '0;
    s_wdata_i      <= '0;
    probe_en       <= 1'b0;
    tgt0           <= CAP_ADDR0_RST;
    tgt1           <= CAP_ADDR1_RST;
    hs             <= '0;
    feat_wr_en_i   <= 1'b0;
    feat_wr_addr_i <= '0;
    wh_addr_i      <= '0;
    sppe_lanes_i   <= '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    read_all(0); // reset values.
    probe_en <= 1'b1;
    repeat (8) @(posedge clk);
    read_all(0); // flags only partly set.
    repeat (200) @(posedge clk);
    read_all(0);
    axi_write(REG_FEAT_THRESH, 32'h0000_f800);
    axi_write(REG_CTRL, 32'h0000_0021); // clear under live probes.
    repeat (60) @(posedge clk);
    read_all(0);
    probe_en <= 1'b0;
    repeat (2) @(posedge clk);
    axi_write(REG_CTRL, 32'h0000_0021); // clear, keep lane 2.
    read_all(0);
    probe_en <= 1'b1;
    tgt0 <= 14'h1234;
    tgt1 <= 14'h0abc;
    axi_write(REG_CAP_ADDR0, 32'h0000_1234);
    axi_write(REG_CAP_ADDR1, 32'h0000_0abc);
    axi_write(REG_CTRL, 32'h0000_00b0);
    repeat (300) @(posedge clk);
    read_all(0);
    axi_write(REG_ID, 32'hffff_ffff);
    axi_write(REG_STATUS, 32'hffff_ffff);
    axi_write(REG_CNT_LO, 32'h1234_5678);
    axi_write(8'h28, 32'h0000_0001);
    axi_write(8'h06, 32'h0000_0001);
    axi_read(8'h30, 0);
    axi_read(8'h0d, 0);
    read_all(0);
    read_all(20); // stalled R beats.
    if (UUT.u_checker.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      abort_run("an AXI4-Lite protocol assertion failed during the run");
    end
  end

endmodule

// File: filelist.f
rtl/gnn_debug_pkg.sv
rtl/dbg_axil_decode.sv
rtl/dbg_event_monitor.sv
rtl/dbg_read_result.sv
rtl/gnn_debug_top.sv
sim/gnn_debug_checker.sv
sim/tb_gnn_debug.sv

// File: Bender.yml
package:
  name: gnn_debug

sources:
  - rtl/gnn_debug_pkg.sv
  - rtl/dbg_axil_decode.sv
  - rtl/dbg_event_monitor.sv
  - rtl/dbg_read_result.sv
  - rtl/gnn_debug_top.sv
  - target: simulation
    files:
      - sim/gnn_debug_checker.sv
      - sim/tb_gnn_debug.sv
